//--- source/rename_config.svh
`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// Group and writeback widths
`define RENAME_WIDTH 2
`define WB_WIDTH 2

// Architectural register names
`define ARCH_REGS 32
`define REG_BITS 5

// Physical tags, free count needs one extra bit
`define PHYS_TAGS 64
`define TAG_BITS 6
`define FREE_CNT_BITS 7

// Sequence, load and store numbers
`define SQN_BITS 6

`endif

//--- source/renamePkg.sv
`default_nettype none

`include "rename_config.svh"

package renamePkg;

    typedef logic [`REG_BITS-1:0] RegName;
    typedef logic [`TAG_BITS-1:0] Tag;
    typedef logic [`SQN_BITS-1:0] SqN;

    typedef enum logic [1:0] {
        OP_ALU   = 2'd0,
        OP_LOAD  = 2'd1,
        OP_STORE = 2'd2
    } OpKind;

    // Decoded micro-op from the front end
    typedef struct packed {
        logic valid;
        OpKind kind;
        RegName rs0;
        RegName rs1;
        RegName rd;
        logic [31:0] imm;
    } DecUop;

    // Renamed micro-op for the issue stage
    typedef struct packed {
        OpKind kind;
        logic [31:0] imm;
        RegName nmDst;
        Tag tagA;
        Tag tagB;
        logic availA;
        logic availB;
        Tag tagDst;
        SqN sqN;
        SqN loadSqN;
        SqN storeSqN;
    } RenUop;

    typedef struct packed {
        logic valid;
        RegName nmDst;
        Tag tagDst;
        SqN sqN;
    } CommitUop;

    typedef struct packed {
        logic valid;
        Tag tagDst;
    } WbResult;

    // Mispredicted branch and the counters it carried
    typedef struct packed {
        logic taken;
        SqN sqN;
        SqN loadSqN;
        SqN storeSqN;
    } BranchRecover;

endpackage

`default_nettype wire

//--- source/renameTable.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

module renameTable import renamePkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic recoverTaken,
    input  RegName [2*`RENAME_WIDTH-1:0] lookupNames,
    input  logic [`RENAME_WIDTH-1:0] issueValid,
    input  RegName [`RENAME_WIDTH-1:0] issueNames,
    input  Tag [`RENAME_WIDTH-1:0] issueTags,
    input  logic [`RENAME_WIDTH-1:0] commitValid,
    input  RegName [`RENAME_WIDTH-1:0] commitNames,
    input  Tag [`RENAME_WIDTH-1:0] commitTags,
    input  WbResult [`WB_WIDTH-1:0] wbResults,
    output Tag [2*`RENAME_WIDTH-1:0] lookupTags,
    output logic [2*`RENAME_WIDTH-1:0] lookupAvail,
    output Tag [`RENAME_WIDTH-1:0] commitPrevTags
);

    Tag specMap [`ARCH_REGS];
    logic [`ARCH_REGS-1:0] specReady;
    Tag comMap [`ARCH_REGS];

    Tag specMapNext [`ARCH_REGS];
    logic [`ARCH_REGS-1:0] specReadyNext;
    Tag comMapNext [`ARCH_REGS];

    // Operand lookup, two per slot
    always_comb begin
        for (int k = 0; k < 2*`RENAME_WIDTH; k++) begin
            lookupTags[k] = specMap[lookupNames[k]];
            lookupAvail[k] = specReady[lookupNames[k]];
            // Older slot in this group writes the same register
            for (int j = 0; j < k / 2; j++) begin
                if (issueValid[j] && issueNames[j] == lookupNames[k]) begin
                    lookupTags[k] = issueTags[j];
                    lookupAvail[k] = 1'b0;
                end
            end
            for (int w = 0; w < `WB_WIDTH; w++) begin
                if (wbResults[w].valid && wbResults[w].tagDst == lookupTags[k])
                    lookupAvail[k] = 1'b1;
            end
            if (lookupNames[k] == '0) begin
                lookupTags[k] = '0;
                lookupAvail[k] = 1'b1;
            end
        end
    end

    // Commits in order, so a later commit to the same register sees the earlier one
    always_comb begin
        comMapNext = comMap;
        for (int c = 0; c < `RENAME_WIDTH; c++) begin
            commitPrevTags[c] = comMapNext[commitNames[c]];
            if (commitValid[c])
                comMapNext[commitNames[c]] = commitTags[c];
        end
    end

    always_comb begin
        specMapNext = specMap;
        specReadyNext = specReady;
        if (recoverTaken) begin
            specMapNext = comMapNext;
            specReadyNext = '1;
        end else begin
            for (int r = 0; r < `ARCH_REGS; r++) begin
                for (int w = 0; w < `WB_WIDTH; w++) begin
                    if (wbResults[w].valid && wbResults[w].tagDst == specMap[r])
                        specReadyNext[r] = 1'b1;
                end
            end
            // New mappings win over writebacks
            for (int i = 0; i < `RENAME_WIDTH; i++) begin
                if (issueValid[i]) begin
                    specMapNext[issueNames[i]] = issueTags[i];
                    specReadyNext[issueNames[i]] = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < `ARCH_REGS; r++) begin
                specMap[r] <= Tag'(r);
                comMap[r] <= Tag'(r);
            end
            specReady <= '1;
        end else begin
            specMap <= specMapNext;
            specReady <= specReadyNext;
            comMap <= comMapNext;
        end
    end

endmodule

`default_nettype wire

//--- source/tagFreeList.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

module tagFreeList import renamePkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic recoverTaken,
    input  logic [`RENAME_WIDTH-1:0] allocValid,
    input  logic [`RENAME_WIDTH-1:0] commitValid,
    input  Tag [`RENAME_WIDTH-1:0] commitPrevTags,
    output Tag [`RENAME_WIDTH-1:0] allocTags,
    output logic [`FREE_CNT_BITS-1:0] freeCount
);

    // Pointers carry a wrap bit above the index
    typedef logic [`FREE_CNT_BITS-1:0] QPtr;

    Tag fifo [`PHYS_TAGS];
    QPtr specRd;
    QPtr comRd;
    QPtr wrPtr;

    QPtr allocCnt;
    QPtr pushCnt;
    QPtr allocOffs [`RENAME_WIDTH];
    QPtr pushOffs [`RENAME_WIDTH];

    assign freeCount = wrPtr - specRd;

    // Only allocating slots consume entries, likewise only used commits push
    always_comb begin
        allocCnt = '0;
        pushCnt = '0;
        for (int k = 0; k < `RENAME_WIDTH; k++) begin
            allocOffs[k] = specRd + allocCnt;
            pushOffs[k] = wrPtr + pushCnt;
            allocTags[k] = fifo[allocOffs[k][`TAG_BITS-1:0]];
            if (allocValid[k])
                allocCnt = allocCnt + 1'b1;
            if (commitValid[k])
                pushCnt = pushCnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            // Tags above the architectural range start out free
            for (int i = 0; i < `PHYS_TAGS; i++)
                fifo[i] <= Tag'(i + `ARCH_REGS);
            specRd <= '0;
            comRd <= '0;
            wrPtr <= QPtr'(`PHYS_TAGS - `ARCH_REGS);
        end else begin
            for (int k = 0; k < `RENAME_WIDTH; k++) begin
                if (commitValid[k])
                    fifo[pushOffs[k][`TAG_BITS-1:0]] <= commitPrevTags[k];
            end
            wrPtr <= wrPtr + pushCnt;
            comRd <= comRd + pushCnt;
            // Commits retire allocations in the same order they were handed out
            if (recoverTaken)
                specRd <= comRd + pushCnt;
            else
                specRd <= specRd + allocCnt;
        end
    end

endmodule

`default_nettype wire

//--- source/seqAllocator.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

module seqAllocator import renamePkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic accept,
    input  logic [`RENAME_WIDTH-1:0] slotValid,
    input  OpKind [`RENAME_WIDTH-1:0] slotKind,
    input  BranchRecover recover,
    output SqN [`RENAME_WIDTH-1:0] slotSqN,
    output SqN [`RENAME_WIDTH-1:0] slotLoadSqN,
    output SqN [`RENAME_WIDTH-1:0] slotStoreSqN,
    output SqN nextSqN
);

    SqN sqN;
    SqN loadSqN;
    SqN storeSqN;

    SqN sqNEnd;
    SqN loadSqNEnd;
    SqN storeSqNEnd;

    assign nextSqN = sqN;

    // Each slot gets the running counts of the slots before it
    always_comb begin
        sqNEnd = sqN;
        loadSqNEnd = loadSqN;
        storeSqNEnd = storeSqN;
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            slotSqN[i] = sqNEnd;
            slotLoadSqN[i] = loadSqNEnd;
            slotStoreSqN[i] = storeSqNEnd;
            if (slotValid[i]) begin
                sqNEnd = sqNEnd + 1'b1;
                if (slotKind[i] == OP_LOAD)
                    loadSqNEnd = loadSqNEnd + 1'b1;
                if (slotKind[i] == OP_STORE)
                    storeSqNEnd = storeSqNEnd + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sqN <= '0;
            loadSqN <= '0;
            storeSqN <= '0;
        end else if (recover.taken) begin
            sqN <= recover.sqN + 1'b1;
            loadSqN <= recover.loadSqN;
            storeSqN <= recover.storeSqN;
        end else if (accept) begin
            sqN <= sqNEnd;
            loadSqN <= loadSqNEnd;
            storeSqN <= storeSqNEnd;
        end
    end

endmodule

`default_nettype wire

//--- source/renameStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

module renameStage import renamePkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic en,
    input  logic advance,
    input  DecUop [`RENAME_WIDTH-1:0] decUops,
    input  CommitUop [`RENAME_WIDTH-1:0] comUops,
    input  WbResult [`WB_WIDTH-1:0] wbResults,
    input  BranchRecover recover,
    output logic stall,
    output logic [`RENAME_WIDTH-1:0] renValid,
    output RenUop [`RENAME_WIDTH-1:0] renUops,
    output SqN nextSqN
);

    logic accept;
    logic [`RENAME_WIDTH-1:0] slotValid;
    logic [`RENAME_WIDTH-1:0] slotWrites;
    logic [`RENAME_WIDTH-1:0] issueValid;
    OpKind [`RENAME_WIDTH-1:0] slotKind;
    RegName [`RENAME_WIDTH-1:0] destNames;
    logic [`FREE_CNT_BITS-1:0] needTags;

    RegName [2*`RENAME_WIDTH-1:0] lookupNames;
    Tag [2*`RENAME_WIDTH-1:0] lookupTags;
    logic [2*`RENAME_WIDTH-1:0] lookupAvail;

    logic [`RENAME_WIDTH-1:0] commitValid;
    RegName [`RENAME_WIDTH-1:0] commitNames;
    Tag [`RENAME_WIDTH-1:0] commitTags;
    Tag [`RENAME_WIDTH-1:0] commitPrevTags;

    Tag [`RENAME_WIDTH-1:0] allocTags;
    logic [`FREE_CNT_BITS-1:0] freeCount;

    SqN [`RENAME_WIDTH-1:0] slotSqN;
    SqN [`RENAME_WIDTH-1:0] slotLoadSqN;
    SqN [`RENAME_WIDTH-1:0] slotStoreSqN;

    always_comb begin
        needTags = '0;
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            slotValid[i] = decUops[i].valid;
            slotKind[i] = decUops[i].kind;
            destNames[i] = decUops[i].rd;
            // r0 never takes a tag
            slotWrites[i] = decUops[i].valid && decUops[i].rd != '0;
            lookupNames[2*i] = decUops[i].rs0;
            lookupNames[2*i+1] = decUops[i].rs1;
            if (slotWrites[i])
                needTags = needTags + 1'b1;
        end
    end

    assign stall = freeCount < needTags;
    assign accept = en && advance && !stall && !recover.taken;
    assign issueValid = {`RENAME_WIDTH{accept}} & slotWrites;

    // Commits younger than a mispredicted branch are dropped
    always_comb begin
        for (int c = 0; c < `RENAME_WIDTH; c++) begin
            commitNames[c] = comUops[c].nmDst;
            commitTags[c] = comUops[c].tagDst;
            commitValid[c] = comUops[c].valid && comUops[c].nmDst != '0
                && (!recover.taken || $signed(SqN'(comUops[c].sqN - recover.sqN)) <= 0);
        end
    end

    renameTable rt (
        .clk(clk),
        .rst(rst),
        .recoverTaken(recover.taken),
        .lookupNames(lookupNames),
        .issueValid(issueValid),
        .issueNames(destNames),
        .issueTags(allocTags),
        .commitValid(commitValid),
        .commitNames(commitNames),
        .commitTags(commitTags),
        .wbResults(wbResults),
        .lookupTags(lookupTags),
        .lookupAvail(lookupAvail),
        .commitPrevTags(commitPrevTags)
    );

    tagFreeList fl (
        .clk(clk),
        .rst(rst),
        .recoverTaken(recover.taken),
        .allocValid(issueValid),
        .commitValid(commitValid),
        .commitPrevTags(commitPrevTags),
        .allocTags(allocTags),
        .freeCount(freeCount)
    );

    seqAllocator sa (
        .clk(clk),
        .rst(rst),
        .accept(accept),
        .slotValid(slotValid),
        .slotKind(slotKind),
        .recover(recover),
        .slotSqN(slotSqN),
        .slotLoadSqN(slotLoadSqN),
        .slotStoreSqN(slotStoreSqN),
        .nextSqN(nextSqN)
    );

    // Group is held only while enabled and the next stage is not taking it
    always_ff @(posedge clk) begin
        if (rst || recover.taken)
            renValid <= '0;
        else if (accept)
            renValid <= slotValid;
        else if (!en || advance)
            renValid <= '0;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            for (int i = 0; i < `RENAME_WIDTH; i++) begin
                renUops[i].kind <= decUops[i].kind;
                renUops[i].imm <= decUops[i].imm;
                renUops[i].nmDst <= decUops[i].rd;
                renUops[i].tagA <= lookupTags[2*i];
                renUops[i].tagB <= lookupTags[2*i+1];
                renUops[i].availA <= lookupAvail[2*i];
                renUops[i].availB <= lookupAvail[2*i+1];
                renUops[i].tagDst <= slotWrites[i] ? allocTags[i] : Tag'(0);
                renUops[i].sqN <= slotSqN[i];
                renUops[i].loadSqN <= slotLoadSqN[i];
                renUops[i].storeSqN <= slotStoreSqN[i];
            end
        end else if (en && !advance) begin
            // Keep held operands up to date with results
            for (int w = 0; w < `WB_WIDTH; w++) begin
                for (int i = 0; i < `RENAME_WIDTH; i++) begin
                    if (wbResults[w].valid && renValid[i]) begin
                        if (renUops[i].tagA == wbResults[w].tagDst)
                            renUops[i].availA <= 1'b1;
                        if (renUops[i].tagB == wbResults[w].tagDst)
                            renUops[i].availB <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tests/tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Reset held for 8 rising edges
    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

//--- tests/renameTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

module renameTb import renamePkg::*; ();

    localparam int W = `RENAME_WIDTH;
    localparam int RUN_CYCLES = 8 + 160 + 40;

    logic clk, rst, en, advance, stall;
    DecUop [W-1:0] decUops;
    CommitUop [W-1:0] comUops;
    WbResult [`WB_WIDTH-1:0] wbResults;
    BranchRecover recover;
    logic [W-1:0] renValid;
    RenUop [W-1:0] renUops;
    SqN nextSqN;

    // Inputs the tests choose for the next edge
    logic curEn, curAdv;
    DecUop [W-1:0] curDec;
    CommitUop [W-1:0] curCom;
    WbResult [`WB_WIDTH-1:0] curWb;
    BranchRecover curRec;

    // Reference model
    Tag specMap [`ARCH_REGS];
    logic specRdy [`ARCH_REGS];
    Tag comMap [`ARCH_REGS];
    Tag freeQ [`PHYS_TAGS];
    int specRd, comRd, wrPtr;
    SqN mSqN, mLdN, mStN;
    logic [W-1:0] mValid;
    RenUop [W-1:0] mUops;
    CommitUop inflight [$];
    logic lastAccept, lastStall;

    logic [W-1:0] pendValid, expValid;
    RenUop [W-1:0] pendUops, expUops;
    SqN pendNext, expNext;
    logic expStall;

    logic [31:0] lfsr = 32'he688;
    string testName = "reset";
    int errors, errBefore, testsRun, testsFailed;

    tbClock clkGen (.clk(clk), .rst(rst));

    renameStage UUT (
        .clk(clk), .rst(rst), .en(en), .advance(advance),
        .decUops(decUops), .comUops(comUops), .wbResults(wbResults),
        .recover(recover), .stall(stall), .renValid(renValid),
        .renUops(renUops), .nextSqN(nextSqN)
    );

    // Expected group lines up with the DUT register one edge later
    always @(posedge clk) begin
        expValid <= pendValid;
        expUops <= pendUops;
        expNext <= pendNext;
    end

    for (genvar i = 0; i < W; i++) begin : slotChecks
        validCheck: assert property (@(posedge clk) disable iff (rst) renValid[i] == expValid[i])
            else begin
                errors++;
                $display("Error %s renValid[%0d]: expected %b actual %b", testName, i,
                    $sampled(expValid[i]), $sampled(renValid[i]));
            end
        uopCheck: assert property (@(posedge clk) disable iff (rst)
            expValid[i] |-> renUops[i] == expUops[i])
            else begin
                errors++;
                $display("Error %s renUops[%0d]: expected %h actual %h", testName, i,
                    $sampled(expUops[i]), $sampled(renUops[i]));
            end
    end

    stallCheck: assert property (@(posedge clk) disable iff (rst) stall == expStall)
        else begin
            errors++;
            $display("Error %s stall: expected %b actual %b", testName,
                $sampled(expStall), $sampled(stall));
        end
    sqnCheck: assert property (@(posedge clk) disable iff (rst) nextSqN == expNext)
        else begin
            errors++;
            $display("Error %s nextSqN: expected %0d actual %0d", testName,
                $sampled(expNext), $sampled(nextSqN));
        end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] randBits(int n);
        logic [31:0] r;
        logic fb;
        r = '0;
        for (int b = 0; b < n; b++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic DecUop makeUop(OpKind kind, RegName rs0, RegName rs1, RegName rd);
        DecUop u;
        u.valid = 1'b1;
        u.kind = kind;
        u.rs0 = rs0;
        u.rs1 = rs1;
        u.rd = rd;
        u.imm = randBits(32);
        return u;
    endfunction

    function automatic DecUop randUop(logic mixKinds, logic writer);
        logic [1:0] k;
        RegName rd;
        OpKind kind;
        k = mixKinds ? randBits(2) : 2'd0;
        kind = (k == 2'd1) ? OP_LOAD : (k == 2'd2) ? OP_STORE : OP_ALU;
        rd = randBits(5);
        if (writer && rd == '0)
            rd = 5'd1;
        return makeUop(kind, randBits(5), randBits(5), rd);
    endfunction

    task automatic initModel();
        for (int r = 0; r < `ARCH_REGS; r++) begin
            specMap[r] = Tag'(r);
            comMap[r] = Tag'(r);
            specRdy[r] = 1'b1;
        end
        for (int i = 0; i < `PHYS_TAGS; i++)
            freeQ[i] = Tag'(i + `ARCH_REGS);
        specRd = 0;
        comRd = 0;
        wrPtr = `PHYS_TAGS - `ARCH_REGS;
        {mSqN, mLdN, mStN} = '0;
        mValid = '0;
        mUops = '0;
        lastAccept = 1'b1;
    endtask

    // Model update for the chosen inputs before they are driven on this edge
    task automatic cycle();
        int need;
        logic acc;
        logic [W-1:0] writes;
        Tag newTag [W];
        Tag tag;
        logic rdy;
        RegName nm;
        RenUop u;
        SqN diff;
        CommitUop keep [$];
        need = 0;
        for (int i = 0; i < W; i++) begin
            writes[i] = curDec[i].valid && curDec[i].rd != '0;
            if (writes[i])
                need++;
        end
        lastStall = (wrPtr - specRd) < need;
        acc = curEn && curAdv && !lastStall && !curRec.taken;
        lastAccept = acc;
        if (acc) begin
            for (int i = 0; i < W; i++) begin
                u = '0;
                u.kind = curDec[i].kind;
                u.imm = curDec[i].imm;
                u.nmDst = curDec[i].rd;
                newTag[i] = '0;
                if (writes[i]) begin
                    newTag[i] = freeQ[specRd % `PHYS_TAGS];
                    specRd++;
                end
                for (int s = 0; s < 2; s++) begin
                    nm = (s == 0) ? curDec[i].rs0 : curDec[i].rs1;
                    tag = specMap[nm];
                    rdy = specRdy[nm];
                    for (int j = 0; j < i; j++) begin
                        if (writes[j] && curDec[j].rd == nm) begin
                            tag = newTag[j];
                            rdy = 1'b0;
                        end
                    end
                    for (int w = 0; w < `WB_WIDTH; w++)
                        if (curWb[w].valid && curWb[w].tagDst == tag)
                            rdy = 1'b1;
                    if (nm == '0) begin
                        tag = '0;
                        rdy = 1'b1;
                    end
                    if (s == 0) begin
                        u.tagA = tag;
                        u.availA = rdy;
                    end else begin
                        u.tagB = tag;
                        u.availB = rdy;
                    end
                end
                u.tagDst = newTag[i];
                u.sqN = mSqN;
                u.loadSqN = mLdN;
                u.storeSqN = mStN;
                mUops[i] = u;
                mValid[i] = curDec[i].valid;
                if (writes[i])
                    inflight.push_back('{1'b1, curDec[i].rd, newTag[i], mSqN});
                if (curDec[i].valid) begin
                    mSqN++;
                    mLdN += (curDec[i].kind == OP_LOAD);
                    mStN += (curDec[i].kind == OP_STORE);
                end
            end
        end else if (curRec.taken || !curEn || curAdv) begin
            mValid = '0;
        end else begin
            for (int w = 0; w < `WB_WIDTH; w++)
                for (int i = 0; i < W; i++)
                    if (curWb[w].valid && mValid[i]) begin
                        if (mUops[i].tagA == curWb[w].tagDst)
                            mUops[i].availA = 1'b1;
                        if (mUops[i].tagB == curWb[w].tagDst)
                            mUops[i].availB = 1'b1;
                    end
        end
        for (int r = 0; r < `ARCH_REGS; r++)
            for (int w = 0; w < `WB_WIDTH; w++)
                if (curWb[w].valid && curWb[w].tagDst == specMap[r])
                    specRdy[r] = 1'b1;
        for (int i = 0; i < W; i++)
            if (acc && writes[i]) begin
                specMap[curDec[i].rd] = newTag[i];
                specRdy[curDec[i].rd] = 1'b0;
            end
        for (int c = 0; c < W; c++) begin
            diff = curCom[c].sqN - curRec.sqN;
            if (curCom[c].valid && curCom[c].nmDst != '0
                    && (!curRec.taken || $signed(diff) <= 0)) begin
                freeQ[wrPtr % `PHYS_TAGS] = comMap[curCom[c].nmDst];
                comMap[curCom[c].nmDst] = curCom[c].tagDst;
                wrPtr++;
                comRd++;
                void'(inflight.pop_front());
            end
        end
        if (curRec.taken) begin
            foreach (inflight[q]) begin
                diff = inflight[q].sqN - curRec.sqN;
                if ($signed(diff) <= 0)
                    keep.push_back(inflight[q]);
            end
            inflight = keep;
            specMap = comMap;
            for (int r = 0; r < `ARCH_REGS; r++)
                specRdy[r] = 1'b1;
            specRd = comRd;
            mSqN = curRec.sqN + 1'b1;
            mLdN = curRec.loadSqN;
            mStN = curRec.storeSqN;
        end
        pendValid <= mValid;
        pendUops <= mUops;
        pendNext <= mSqN;
        expStall <= lastStall;
        en <= curEn;
        advance <= curAdv;
        decUops <= curDec;
        comUops <= curCom;
        wbResults <= curWb;
        recover <= curRec;
    endtask

    task automatic step();
        @(posedge clk);
        cycle();
    endtask

    task automatic setCommits(int n);
        for (int k = 0; k < W; k++)
            curCom[k] = (k < n && k < inflight.size()) ? inflight[k] : '0;
    endtask

    task automatic idle(int n);
        curDec = '0;
        curCom = '0;
        curWb = '0;
        repeat (n) step();
    endtask

    task automatic randomGroups(int n, logic mixKinds, logic writer, int commits);
        for (int g = 0; g < n; g++) begin
            if (lastAccept)
                for (int k = 0; k < W; k++)
                    curDec[k] = randUop(mixKinds, writer);
            setCommits(commits);
            step();
        end
    endtask

    task automatic startTest(string name);
        testName = name;
        errBefore = errors;
    endtask

    task automatic endTest();
        idle(3);
        testsRun++;
        if (errors != errBefore)
            testsFailed++;
        $display("%s: %s", testName, (errors == errBefore) ? "pass" : "FAIL");
    endtask

    initial begin
        int stallCycles;
        RegName nmOld, nmYoung;
        {en, advance, curEn, curAdv} = '0;
        {decUops, comUops, wbResults, recover} = '0;
        {curDec, curCom, curWb, curRec} = '0;
        {pendValid, expValid, pendUops, expUops, pendNext, expNext, expStall} = '0;
        {errors, testsRun, testsFailed} = '0;
        initModel();
        @(negedge rst);
        curEn = 1'b1;
        curAdv = 1'b1;

        startTest("resetLookup");
        curDec[0] = makeUop(OP_ALU, 5'd3, 5'd5, 5'd0);
        curDec[1] = makeUop(OP_LOAD, 5'd7, 5'd0, 5'd0);
        step();
        endTest();

        startTest("destOrder");
        curDec[0] = makeUop(OP_ALU, 5'd1, 5'd2, 5'd4);
        curDec[1] = makeUop(OP_ALU, 5'd4, 5'd4, 5'd5);
        step();
        randomGroups(6, 1'b0, 1'b0, 2);
        endTest();

        startTest("loadStore");
        randomGroups(10, 1'b1, 1'b0, 2);
        endTest();

        startTest("writeback");
        curDec[0] = makeUop(OP_ALU, 5'd1, 5'd0, 5'd9);
        curDec[1] = makeUop(OP_STORE, 5'd9, 5'd9, 5'd10);
        step();
        curDec = '0;
        curAdv = 1'b0;
        curWb[0] = '{1'b1, inflight[inflight.size()-2].tagDst};
        step();
        curWb = '0;
        repeat (2) step();
        curAdv = 1'b1;
        curDec[0] = makeUop(OP_ALU, 5'd9, 5'd10, 5'd11);
        curWb[1] = '{1'b1, inflight[inflight.size()-1].tagDst};
        step();
        endTest();

        startTest("drain");
        stallCycles = 0;
        for (int c = 0; c < 40 && stallCycles < 4; c++) begin
            randomGroups(1, 1'b0, 1'b1, 0);
            stallCycles += lastStall;
        end
        randomGroups(14, 1'b0, 1'b1, 2);
        endTest();

        startTest("recovery");
        curDec = '0;
        while (inflight.size() > 3) begin
            setCommits((inflight.size() > 4) ? 2 : 1);
            step();
        end
        // Younger group in flight so the branch has an output group to flush
        setCommits(1);
        curDec[0] = makeUop(OP_ALU, 5'd4, 5'd5, 5'd12);
        curDec[1] = makeUop(OP_LOAD, 5'd12, 5'd6, 5'd13);
        step();
        nmOld = inflight[0].nmDst;
        nmYoung = inflight[1].nmDst;
        curRec = '{1'b1, inflight[0].sqN, SqN'(randBits(6)), SqN'(randBits(6))};
        setCommits(2);
        curAdv = 1'b0;
        curDec[0] = makeUop(OP_ALU, 5'd2, 5'd3, 5'd6);
        step();
        curRec = '0;
        curCom = '0;
        curAdv = 1'b1;
        curDec[0] = makeUop(OP_LOAD, nmOld, nmYoung, 5'd7);
        curDec[1] = makeUop(OP_STORE, 5'd7, nmYoung, 5'd8);
        step();
        endTest();

        idle(2);
        $display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
        if (errors == 0 && testsFailed == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

    // Watchdog sized from the reset and test lengths
    initial begin
        #(RUN_CYCLES * 40 * 2);
        $display("Watchdog: the run did not finish in time");
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+source
source/renamePkg.sv
source/renameTable.sv
source/tagFreeList.sv
source/seqAllocator.sv
source/renameStage.sv
tests/tbClock.sv
tests/renameTb.sv
